// File: sim.f
design/exec_pkg.sv
design/exec_alu.sv
design/exec_regfile.sv
design/exec_stage_decode.sv
design/exec_stage_e1.sv
design/exec_stage_wb.sv
design/exec_core_top.sv
sim/tb_clk_gen.sv
sim/tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_exec_core -o tb_exec_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_exec_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

// File: sim/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

//one table row of stimulus
typedef struct packed {
    logic             valid;
    exec_pkg::instr_s instr;
    logic             stall;
    logic             flush;
} stim_s;

logic             i_clk;
logic             i_rst_n;
logic             i_instr_valid;
exec_pkg::instr_s i_instr;
logic             i_stall;
logic             i_flush;
exec_pkg::wb_s    o_wb;

//program table with one row per cycle
string            names[$];
stim_s            stims[$];
//o_wb expected in each cycle and the test that retires there
exec_pkg::wb_s    exps[$];
string            exp_names[$];
logic             table_ready = 1'b0;

//reference model state
exec_pkg::word_t  m_regs [exec_pkg::NUM_REGS];
logic             m_dec_v = 1'b0;
exec_pkg::instr_s m_dec = '0;
string            m_dec_name = "";
logic             m_e1_v = 1'b0;
exec_pkg::reg_idx_t m_e1_rd = '0;
exec_pkg::word_t  m_e1_res = '0;
string            m_e1_name = "";
logic [31:0]      lcg_state = 32'd10;

tb_clk_gen #(.PERIOD_NS(100)) clk_gen (.o_clk(i_clk));

exec_core_top #(
    .DATA_W(16)
) UUT (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_instr_valid(i_instr_valid),
    .i_instr(i_instr),
    .i_stall(i_stall),
    .i_flush(i_flush),
    .o_wb(o_wb)
);

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic exec_pkg::instr_s encode_instr(
    input exec_pkg::alu_op_e  op,
    input exec_pkg::op1_src_e src1,
    input exec_pkg::op2_src_e src2,
    input int                 rd,
    input int                 rs1,
    input int                 rs2,
    input int                 imm
);
    exec_pkg::instr_s ins;
    ins.alu_op  = op;
    ins.op1_src = src1;
    ins.op2_src = src2;
    ins.rd_idx  = 3'(rd);
    ins.rs1_idx = 3'(rs1);
    ins.rs2_idx = 3'(rs2);
    ins.imm     = 4'(imm);
    return ins;
endfunction

//alu per opcode with slt unsigned
function automatic exec_pkg::word_t alu_ref(input exec_pkg::alu_op_e op,
                                            input exec_pkg::word_t a,
                                            input exec_pkg::word_t b);
    case (op)
        exec_pkg::ALU_ADD: return a + b;
        exec_pkg::ALU_SUB: return a - b;
        exec_pkg::ALU_AND: return a & b;
        exec_pkg::ALU_OR:  return a | b;
        exec_pkg::ALU_XOR: return a ^ b;
        exec_pkg::ALU_SLL: return a << b[3:0];
        exec_pkg::ALU_SRL: return a >> b[3:0];
        exec_pkg::ALU_SLT: return (a < b) ? 16'd1 : 16'd0;
        default:           return '0;
    endcase
endfunction

//sequential semantics with all older writes already in m_regs
function automatic exec_pkg::word_t exec_ref(input exec_pkg::instr_s ins);
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    a = (ins.op1_src == exec_pkg::OP1_RS1) ? m_regs[ins.rs1_idx] : '0;
    case (ins.op2_src)
        exec_pkg::OP2_RS2: b = m_regs[ins.rs2_idx];
        exec_pkg::OP2_IMM: b = exec_pkg::word_t'(ins.imm);
        default:           b = 16'd1;
    endcase
    return alu_ref(ins.alu_op, a, b);
endfunction

//one rising edge of the pipeline that retires e1 then advances decode
task automatic model_edge(input stim_s s, input string sname,
                          output exec_pkg::wb_s wb, output string wname);
    wb    = '0;
    wname = sname;
    if (!s.stall) begin
        wb.valid  = m_e1_v;
        wb.rd_idx = m_e1_rd;
        wb.data   = (m_e1_rd != '0) ? m_e1_res : '0;
        if (m_e1_v) begin
            wname = m_e1_name;
        end
        if (m_e1_v && (m_e1_rd != '0)) begin
            m_regs[m_e1_rd] = m_e1_res;
        end
        if (s.flush) begin
            //retiring entry still lands while decode entry and input are lost
            m_e1_v  = 1'b0;
            m_dec_v = 1'b0;
        end else begin
            m_e1_v     = m_dec_v;
            m_e1_rd    = m_dec.rd_idx;
            m_e1_res   = exec_ref(m_dec);
            m_e1_name  = m_dec_name;
            m_dec_v    = s.valid;
            m_dec      = s.instr;
            m_dec_name = sname;
        end
    end
endtask

task automatic push_step(input string name, input logic v, input exec_pkg::instr_s ins,
                         input logic stall, input logic flush);
    stim_s s;
    s.valid = v;
    s.instr = ins;
    s.stall = stall;
    s.flush = flush;
    names.push_back(name);
    stims.push_back(s);
endtask

task automatic reg_op(input string name, input exec_pkg::alu_op_e op,
                      input int rd, input int rs1, input int rs2);
    push_step(name, 1'b1, encode_instr(op, exec_pkg::OP1_RS1, exec_pkg::OP2_RS2,
                                       rd, rs1, rs2, 0), 1'b0, 1'b0);
endtask

task automatic imm_op(input string name, input exec_pkg::alu_op_e op,
                      input int rd, input int rs1, input int imm);
    push_step(name, 1'b1, encode_instr(op, exec_pkg::OP1_RS1, exec_pkg::OP2_IMM,
                                       rd, rs1, 0, imm), 1'b0, 1'b0);
endtask

task automatic load_imm(input string name, input int rd, input int imm);
    push_step(name, 1'b1, encode_instr(exec_pkg::ALU_ADD, exec_pkg::OP1_ZERO,
                                       exec_pkg::OP2_IMM, rd, 0, 0, imm), 1'b0, 1'b0);
endtask

task automatic incr(input string name, input int rd, input int rs1);
    push_step(name, 1'b1, encode_instr(exec_pkg::ALU_ADD, exec_pkg::OP1_RS1,
                                       exec_pkg::OP2_ONE, rd, rs1, 0, 0), 1'b0, 1'b0);
endtask

task automatic bubble(input string name, input int n);
    for (int i = 0; i < n; i++) begin
        push_step(name, 1'b0, '0, 1'b0, 1'b0);
    end
endtask

//valid junk on the input that must be ignored
task automatic stall_for(input string name, input int n);
    for (int i = 0; i < n; i++) begin
        push_step(name, 1'b1, encode_instr(exec_pkg::ALU_ADD, exec_pkg::OP1_ZERO,
                                           exec_pkg::OP2_IMM, 7, 0, 0, 15), 1'b1, 1'b0);
    end
endtask

task automatic flush_once(input string name);
    push_step(name, 1'b1, encode_instr(exec_pkg::ALU_ADD, exec_pkg::OP1_ZERO,
                                       exec_pkg::OP2_IMM, 7, 0, 0, 15), 1'b0, 1'b1);
endtask

task automatic report_mismatch(input string name, input string field,
                               input logic [15:0] expv, input logic [15:0] actv);
    $display("MISMATCH %s o_wb.%s expected 0x%0h actual 0x%0h", name, field, expv, actv);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
endtask

task automatic check_wb(input string name, input exec_pkg::wb_s exp);
    assert (o_wb.valid === exp.valid)
    else report_mismatch(name, "valid", 16'(exp.valid), 16'(o_wb.valid));
    //payload only matters on a retire
    if (exp.valid) begin
        assert (o_wb.rd_idx === exp.rd_idx)
        else report_mismatch(name, "rd_idx", 16'(exp.rd_idx), 16'(o_wb.rd_idx));
        assert (o_wb.data === exp.data)
        else report_mismatch(name, "data", exp.data, o_wb.data);
    end
endtask

initial begin
    exec_pkg::wb_s wb;
    string         wname;
    logic [31:0]   r1;
    logic [31:0]   r2;
    logic [1:0]    s2b;
    i_rst_n       = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_stall       = 1'b0;
    i_flush       = 1'b0;
    for (int i = 0; i < exec_pkg::NUM_REGS; i++) begin
        m_regs[i] = '0;
    end

    //every opcode with imm / reg / one operands
    load_imm("li_x1", 1, 9);
    load_imm("li_x2", 2, 3);
    imm_op("sll_imm", exec_pkg::ALU_SLL, 3, 1, 12);
    reg_op("or_reg", exec_pkg::ALU_OR, 4, 3, 1);
    reg_op("sub_reg", exec_pkg::ALU_SUB, 5, 4, 2);
    imm_op("and_imm", exec_pkg::ALU_AND, 6, 5, 14);
    reg_op("xor_reg", exec_pkg::ALU_XOR, 7, 4, 5);
    imm_op("srl_imm", exec_pkg::ALU_SRL, 1, 3, 4);
    incr("add_one", 2, 2);
    reg_op("sll_reg", exec_pkg::ALU_SLL, 3, 4, 2);
    reg_op("srl_reg", exec_pkg::ALU_SRL, 6, 4, 2);
    reg_op("slt_lt", exec_pkg::ALU_SLT, 3, 5, 4);
    reg_op("slt_ge", exec_pkg::ALU_SLT, 6, 4, 5);
    reg_op("sub_wrap", exec_pkg::ALU_SUB, 7, 2, 4);
    imm_op("xor_imm", exec_pkg::ALU_XOR, 1, 7, 10);
    push_step("neg_zero_op1", 1'b1, encode_instr(exec_pkg::ALU_SUB, exec_pkg::OP1_ZERO,
                                                 exec_pkg::OP2_RS2, 5, 0, 4, 0), 1'b0, 1'b0);
    //distance 1 through forwarding and distance 2 through write-through
    load_imm("dep_seed", 1, 1);
    incr("dep1_a", 1, 1);
    incr("dep1_b", 1, 1);
    reg_op("dep1_both", exec_pkg::ALU_ADD, 2, 1, 1);
    imm_op("dep_filler", exec_pkg::ALU_OR, 3, 4, 1);
    reg_op("dep2_rs1", exec_pkg::ALU_SUB, 4, 2, 1);
    reg_op("dep2_rs2", exec_pkg::ALU_ADD, 5, 3, 4);
    //x0 writes retire as zero and reads stay zero
    imm_op("x0_write", exec_pkg::ALU_ADD, 0, 1, 7);
    reg_op("x0_read_next", exec_pkg::ALU_OR, 3, 0, 0);
    imm_op("x0_read_imm", exec_pkg::ALU_OR, 4, 0, 5);
    //stall inside a dependent chain
    load_imm("st_seed", 5, 2);
    incr("st_a", 5, 5);
    reg_op("st_b", exec_pkg::ALU_ADD, 6, 5, 5);
    stall_for("stall_mid", 4);
    reg_op("st_c", exec_pkg::ALU_SUB, 7, 6, 5);
    reg_op("st_d", exec_pkg::ALU_XOR, 5, 7, 6);
    bubble("st_gap", 1);
    stall_for("stall_short", 1);
    incr("st_e", 5, 5);
    //flush drops the decode entry and the input of that cycle
    load_imm("fl_keep", 6, 11);
    imm_op("fl_retire", exec_pkg::ALU_ADD, 6, 6, 15);
    imm_op("fl_drop", exec_pkg::ALU_ADD, 7, 6, 15);
    flush_once("flush");
    reg_op("fl_read", exec_pkg::ALU_OR, 1, 6, 7);
    reg_op("fl_read_dep", exec_pkg::ALU_ADD, 2, 1, 7);
    //random tail
    for (int i = 0; i < 40; i++) begin
        r1  = lcg_next();
        r2  = lcg_next();
        s2b = (r1[22:21] == 2'd3) ? 2'd1 : r1[22:21];
        push_step($sformatf("random_%0d", i), 1'b1,
                  encode_instr(exec_pkg::alu_op_e'(r1[18:16]),
                               (r2[20:18] == 3'd0) ? exec_pkg::OP1_ZERO : exec_pkg::OP1_RS1,
                               exec_pkg::op2_src_e'(s2b), int'(r1[25:23]), int'(r1[28:26]),
                               int'(r2[31:29]), int'(r2[27:24])), 1'b0, 1'b0);
    end
    bubble("drain", 4);

    //expected o_wb per cycle starting with the empty cycle out of reset
    exps.push_back('0);
    exp_names.push_back("reset");
    foreach (stims[j]) begin
        model_edge(stims[j], names[j], wb, wname);
        exps.push_back(wb);
        exp_names.push_back(wname);
    end
    table_ready = 1'b1;

    repeat (2) @(posedge i_clk);
    #10;
    i_rst_n = 1'b1;
    for (int j = 0; j < stims.size(); j++) begin
        @(posedge i_clk);
        #10;
        check_wb(exp_names[j], exps[j]);
        i_instr_valid = stims[j].valid;
        i_instr       = stims[j].instr;
        i_stall       = stims[j].stall;
        i_flush       = stims[j].flush;
    end
    //edge that takes the last row
    @(posedge i_clk);
    #10;
    check_wb(exp_names[stims.size()], exps[stims.size()]);
    $display("Verification passed");
    $finish;
end

//watchdog over table length plus margin in clock periods
initial begin
    wait (table_ready);
    #((stims.size() + 10) * 100);
    $display("timeout: table did not finish within the cycle limit");
    $display("Verification failed");
    $fatal(1, "watchdog expired");
end

endmodule : tb_exec_core

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

//free running, starts low
initial begin
    o_clk = 1'b0;
    forever begin
        #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
end

endmodule : tb_clk_gen

// File: design/exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top #(
    parameter int DATA_W = 16
) (
    //clock and reset
    input  logic             i_clk,
    input  logic             i_rst_n,

    //instruction in
    input  logic             i_instr_valid,
    input  exec_pkg::instr_s i_instr,

    //hazard levels, never both high
    input  logic             i_stall,
    input  logic             i_flush,

    //retired writes
    output exec_pkg::wb_s    o_wb
);

//decode <-> regfile read
logic [exec_pkg::REG_IDX_W-1:0] rs1_idx;
logic [exec_pkg::REG_IDX_W-1:0] rs2_idx;
logic [DATA_W-1:0]              rs1_rdata;
logic [DATA_W-1:0]              rs2_rdata;

//wb -> regfile write
logic                           rf_we;
logic [exec_pkg::REG_IDX_W-1:0] rf_idx;
logic [DATA_W-1:0]              rf_data;

//stage structs
exec_pkg::d_to_e1_s             d_to_e1;
exec_pkg::e1_to_e2_s            e1_to_e2;

exec_regfile #(
    .DATA_W(DATA_W)
) regfile (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_rs1_idx(rs1_idx),
    .i_rs2_idx(rs2_idx),
    .o_rs1_rdata(rs1_rdata),
    .o_rs2_rdata(rs2_rdata),
    .i_we(rf_we),
    .i_wr_idx(rf_idx),
    .i_wr_data(rf_data)
);

exec_stage_decode stage_d (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_instr_valid(i_instr_valid),
    .i_instr(i_instr),
    .i_stall(i_stall),
    .i_flush(i_flush),
    .o_rs1_idx(rs1_idx),
    .o_rs2_idx(rs2_idx),
    .i_rs1_rdata(rs1_rdata),
    .i_rs2_rdata(rs2_rdata),
    .o_d_to_e1(d_to_e1)
);

exec_stage_e1 #(
    .DATA_W(DATA_W)
) stage_e1 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_stall(i_stall),
    .i_flush(i_flush),
    .i_d_to_e1(d_to_e1),
    .o_e1_to_e2(e1_to_e2)
);

exec_stage_wb stage_wb (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_stall(i_stall),
    .i_e1_to_e2(e1_to_e2),
    .o_rf_we(rf_we),
    .o_rf_idx(rf_idx),
    .o_rf_data(rf_data),
    .o_wb(o_wb)
);

endmodule : exec_core_top

// File: design/exec_stage_wb.sv
`timescale 1ns/1ps

module exec_stage_wb (
    //clock and reset
    input  logic                           i_clk,
    input  logic                           i_rst_n,

    input  logic                           i_stall,

    //from e1
    input  exec_pkg::e1_to_e2_s            i_e1_to_e2,

    //register file write
    output logic                           o_rf_we,
    output logic [exec_pkg::REG_IDX_W-1:0] o_rf_idx,
    output exec_pkg::word_t                o_rf_data,

    //retired write
    output exec_pkg::wb_s                  o_wb
);

//write lands on the same edge that retires the entry
assign o_rf_we   = i_e1_to_e2.valid && i_e1_to_e2.rd_we && !i_stall;
assign o_rf_idx  = i_e1_to_e2.rd_idx;
assign o_rf_data = i_e1_to_e2.alu_result;

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        o_wb.valid <= 1'b0;
    end else begin
        o_wb.valid <= i_e1_to_e2.valid && !i_stall;
    end

    if (!i_stall) begin
        o_wb.rd_idx <= i_e1_to_e2.rd_idx;
        //x0 retires with zero data
        o_wb.data   <= i_e1_to_e2.rd_we ? i_e1_to_e2.alu_result : '0;
    end
end

//a held entry stays in e1 and does not retire during the stall
assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_stall && i_e1_to_e2.valid) |=> (i_e1_to_e2.valid && !o_wb.valid));

endmodule : exec_stage_wb

// File: design/exec_stage_e1.sv
`timescale 1ns/1ps

module exec_stage_e1 #(
    parameter int DATA_W = 16
) (
    //clock and reset
    input  logic                i_clk,
    input  logic                i_rst_n,

    //hazard levels
    input  logic                i_stall,
    input  logic                i_flush,

    //from decode
    input  exec_pkg::d_to_e1_s  i_d_to_e1,

    //to writeback
    output exec_pkg::e1_to_e2_s o_e1_to_e2
);

//stage structs are fixed at the package width
if (DATA_W != exec_pkg::WORD_W) begin : g_width_check
    $error("DATA_W must equal exec_pkg::WORD_W");
end

logic [1:0][DATA_W-1:0] alu_operands;
logic [DATA_W-1:0]      alu_result;
logic [DATA_W-1:0]      imm_ext;
logic [DATA_W-1:0]      rs1;
logic [DATA_W-1:0]      rs2;
logic                   fwd_rs1;
logic                   fwd_rs2;

exec_alu #(
    .DATA_W(DATA_W)
) alu (
    .i_operands(alu_operands),
    .i_op(i_d_to_e1.alu_op),
    .o_result(alu_result)
);

//only in-flight producer is our own output register
//two ahead is covered by regfile write-through
assign fwd_rs1 = o_e1_to_e2.valid && o_e1_to_e2.rd_we
    && (o_e1_to_e2.rd_idx == i_d_to_e1.rs1_idx);
assign fwd_rs2 = o_e1_to_e2.valid && o_e1_to_e2.rd_we
    && (o_e1_to_e2.rd_idx == i_d_to_e1.rs2_idx);

assign rs1 = fwd_rs1 ? o_e1_to_e2.alu_result : i_d_to_e1.rs1_rdata;
assign rs2 = fwd_rs2 ? o_e1_to_e2.alu_result : i_d_to_e1.rs2_rdata;

//zero extended
assign imm_ext = DATA_W'(i_d_to_e1.imm);

//op1
always_comb begin
    unique case (i_d_to_e1.op1_src)
        exec_pkg::OP1_RS1:  alu_operands[0] = rs1;
        exec_pkg::OP1_ZERO: alu_operands[0] = '0;
        default:            alu_operands[0] = '0;
    endcase
end

//op2
always_comb begin
    unique case (i_d_to_e1.op2_src)
        exec_pkg::OP2_RS2: alu_operands[1] = rs2;
        exec_pkg::OP2_IMM: alu_operands[1] = imm_ext;
        exec_pkg::OP2_ONE: alu_operands[1] = DATA_W'(1);
        default:           alu_operands[1] = '0;
    endcase
end

//execute register
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        o_e1_to_e2.valid <= 1'b0;
    end else if (i_flush) begin
        o_e1_to_e2.valid <= 1'b0;
    end else if (!i_stall) begin
        o_e1_to_e2.valid <= i_d_to_e1.valid;
    end

    if (!i_stall) begin
        //passthroughs
        o_e1_to_e2.rd_idx     <= i_d_to_e1.rd_idx;
        o_e1_to_e2.rd_we      <= i_d_to_e1.rd_we;
        o_e1_to_e2.alu_result <= alu_result;
    end
end

//hazard controls are exclusive
assert property (@(posedge i_clk) disable iff (!i_rst_n) !(i_flush && i_stall));

endmodule : exec_stage_e1

// File: design/exec_stage_decode.sv
`timescale 1ns/1ps

module exec_stage_decode (
    //clock and reset
    input  logic                           i_clk,
    input  logic                           i_rst_n,

    //instruction in, plain strobe
    input  logic                           i_instr_valid,
    input  exec_pkg::instr_s               i_instr,

    //hazard levels
    input  logic                           i_stall,
    input  logic                           i_flush,

    //register file read
    output logic [exec_pkg::REG_IDX_W-1:0] o_rs1_idx,
    output logic [exec_pkg::REG_IDX_W-1:0] o_rs2_idx,
    input  exec_pkg::word_t                i_rs1_rdata,
    input  exec_pkg::word_t                i_rs2_rdata,

    //to e1
    output exec_pkg::d_to_e1_s             o_d_to_e1
);

exec_pkg::d_to_e1_s d_next;

//read indices straight from the instruction
assign o_rs1_idx = i_instr.rs1_idx;
assign o_rs2_idx = i_instr.rs2_idx;

//field split
always_comb begin
    d_next.valid     = i_instr_valid;
    d_next.rd_idx    = i_instr.rd_idx;
    //no write for x0
    d_next.rd_we     = (i_instr.rd_idx != '0);
    d_next.rs1_idx   = i_instr.rs1_idx;
    d_next.rs2_idx   = i_instr.rs2_idx;
    d_next.rs1_rdata = i_rs1_rdata;
    d_next.rs2_rdata = i_rs2_rdata;
    d_next.imm       = i_instr.imm;
    d_next.alu_op    = i_instr.alu_op;
    d_next.op1_src   = i_instr.op1_src;
    d_next.op2_src   = i_instr.op2_src;
end

//decode register
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        o_d_to_e1.valid <= 1'b0;
    end else if (i_flush) begin
        o_d_to_e1.valid <= 1'b0;
    end else if (!i_stall) begin
        o_d_to_e1.valid <= d_next.valid;
    end

    //payload only moves when not stalled
    if (!i_stall) begin
        o_d_to_e1.rd_idx    <= d_next.rd_idx;
        o_d_to_e1.rd_we     <= d_next.rd_we;
        o_d_to_e1.rs1_idx   <= d_next.rs1_idx;
        o_d_to_e1.rs2_idx   <= d_next.rs2_idx;
        o_d_to_e1.rs1_rdata <= d_next.rs1_rdata;
        o_d_to_e1.rs2_rdata <= d_next.rs2_rdata;
        o_d_to_e1.imm       <= d_next.imm;
        o_d_to_e1.alu_op    <= d_next.alu_op;
        o_d_to_e1.op1_src   <= d_next.op1_src;
        o_d_to_e1.op2_src   <= d_next.op2_src;
    end
end

//an accepted instruction never carries the unused op2 encoding into e1
assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_instr_valid && !i_stall && !i_flush) |->
        (i_instr.op2_src inside {exec_pkg::OP2_RS2, exec_pkg::OP2_IMM, exec_pkg::OP2_ONE}));

endmodule : exec_stage_decode

// File: design/exec_regfile.sv
`timescale 1ns/1ps

module exec_regfile #(
    parameter int DATA_W = 16
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,

    //read ports, combinational
    input  logic [exec_pkg::REG_IDX_W-1:0]     i_rs1_idx,
    input  logic [exec_pkg::REG_IDX_W-1:0]     i_rs2_idx,
    output logic [DATA_W-1:0]                  o_rs1_rdata,
    output logic [DATA_W-1:0]                  o_rs2_rdata,

    //write port
    input  logic                               i_we,
    input  logic [exec_pkg::REG_IDX_W-1:0]     i_wr_idx,
    input  logic [DATA_W-1:0]                  i_wr_data
);

//x0 has no storage
logic [DATA_W-1:0] regs [1:exec_pkg::NUM_REGS-1];

//x0 reads zero, then write-through, then storage
function automatic logic [DATA_W-1:0] read_port(input logic [exec_pkg::REG_IDX_W-1:0] idx);
    if (idx == '0) begin
        return '0;
    end else if (i_we && (idx == i_wr_idx)) begin
        return i_wr_data;
    end
    return regs[idx];
endfunction

//reads follow the storage and the write port as well as the index
always_comb begin
    o_rs1_rdata = read_port(i_rs1_idx);
    o_rs2_rdata = read_port(i_rs2_idx);
end

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        for (int i = 1; i < exec_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (i_we && (i_wr_idx != '0)) begin
        regs[i_wr_idx] <= i_wr_data;
    end
end

//wb never requests a write to x0
assert property (@(posedge i_clk) disable iff (!i_rst_n) i_we |-> (i_wr_idx != '0));

endmodule : exec_regfile

// File: design/exec_alu.sv
`timescale 1ns/1ps

module exec_alu #(
    parameter int DATA_W = 16
) (
    //operand 1 in [0], operand 2 in [1]
    input  logic [1:0][DATA_W-1:0] i_operands,
    input  exec_pkg::alu_op_e      i_op,
    output logic [DATA_W-1:0]      o_result
);

logic [DATA_W-1:0] op1;
logic [DATA_W-1:0] op2;
//shift amount from the low four bits only
logic [3:0]        shamt;

assign op1   = i_operands[0];
assign op2   = i_operands[1];
assign shamt = op2[3:0];

always_comb begin
    unique case (i_op)
        exec_pkg::ALU_ADD: o_result = op1 + op2;
        exec_pkg::ALU_SUB: o_result = op1 - op2;
        exec_pkg::ALU_AND: o_result = op1 & op2;
        exec_pkg::ALU_OR:  o_result = op1 | op2;
        exec_pkg::ALU_XOR: o_result = op1 ^ op2;
        exec_pkg::ALU_SLL: o_result = op1 << shamt;
        //logical, zero fill
        exec_pkg::ALU_SRL: o_result = op1 >> shamt;
        //both operands treated as unsigned
        exec_pkg::ALU_SLT: o_result = DATA_W'(op1 < op2);
    endcase
end

endmodule : exec_alu

// File: design/exec_pkg.sv
package exec_pkg;

//register file geometry
localparam int NUM_REGS  = 8;
localparam int REG_IDX_W = 3;

//payload width of the stage structs
localparam int WORD_W = 16;
//immediate field as carried in the instruction
localparam int IMM_W  = 4;

typedef logic [WORD_W-1:0]    word_t;
typedef logic [REG_IDX_W-1:0] reg_idx_t;
typedef logic [IMM_W-1:0]     imm_t;

typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    //unsigned compare
    ALU_SLT = 3'd7
} alu_op_e;

typedef enum logic [1:0] {
    OP1_RS1  = 2'd0,
    OP1_ZERO = 2'd1
} op1_src_e;

//2'd3 left undefined
typedef enum logic [1:0] {
    OP2_RS2 = 2'd0,
    OP2_IMM = 2'd1,
    OP2_ONE = 2'd2
} op2_src_e;

//instruction word as seen on the core input, 20 bits
typedef struct packed {
    alu_op_e  alu_op;
    op1_src_e op1_src;
    op2_src_e op2_src;
    reg_idx_t rd_idx;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    imm_t     imm;
} instr_s;

typedef struct packed {
    logic     valid;
    reg_idx_t rd_idx;
    logic     rd_we;
    //source indices kept for forwarding in e1
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_rdata;
    word_t    rs2_rdata;
    imm_t     imm;
    alu_op_e  alu_op;
    op1_src_e op1_src;
    op2_src_e op2_src;
} d_to_e1_s;

typedef struct packed {
    logic     valid;
    reg_idx_t rd_idx;
    logic     rd_we;
    word_t    alu_result;
} e1_to_e2_s;

//retired write, visible at the top
typedef struct packed {
    logic     valid;
    reg_idx_t rd_idx;
    word_t    data;
} wb_s;

endpackage : exec_pkg
